//--- hdl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  // Geometry fixed at four ways and 32-byte lines
  localparam int NUM_WAYS    = 4;
  localparam int NUM_SETS    = 16;
  localparam int OFFSET_BITS = 5;
  localparam int SET_BITS    = 4;
  localparam int TAG_BITS    = 23;

  localparam int ADDR_BITS  = 32;
  localparam int WORD_BITS  = 32;
  localparam int LINE_BYTES = 1 << OFFSET_BITS;
  localparam int LINE_BITS  = LINE_BYTES * 8;

  typedef logic [ADDR_BITS-1:0]     addr_t;
  typedef logic [WORD_BITS-1:0]     word_t;
  typedef logic [WORD_BITS/8-1:0]   wmask_t;
  typedef logic [LINE_BITS-1:0]     line_t;
  typedef logic [LINE_BYTES-1:0]    line_mask_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [SET_BITS-1:0]      set_idx_t;
  typedef logic [NUM_WAYS-1:0]      way_vec_t;

  // Tree bit 0 is the root, bit 1 the left pair and bit 2 the right pair
  typedef logic [2:0]               plru_t;

endpackage

`default_nettype wire

//--- hdl/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

  // Miss handling states of the cache controller
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITEBACK,
    ALLOCATE,
    REFILL
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/dcache_arrays.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_arrays
  import cache_geom_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire set_idx_t    set_idx,
  input  wire way_vec_t    way_we,
  input  wire tag_t        wr_tag,
  input  wire              wr_dirty,
  input  wire              wr_valid,
  input  wire line_t       wr_line,
  input  wire line_mask_t  wr_line_mask,
  output tag_t             rd_tags [NUM_WAYS],
  output way_vec_t         rd_dirty,
  output way_vec_t         rd_valid,
  output line_t            rd_lines [NUM_WAYS]
);

  tag_t                tag_mem   [NUM_WAYS][NUM_SETS];
  line_t               data_mem  [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] dirty_mem [NUM_WAYS];
  logic [NUM_SETS-1:0] valid_mem [NUM_WAYS];

  // Tag, dirty and data storage with read-before-write
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_we[w]) begin
        tag_mem[w][set_idx]   <= wr_tag;
        dirty_mem[w][set_idx] <= wr_dirty;
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (wr_line_mask[b]) begin
            data_mem[w][set_idx][b*8 +: 8] <= wr_line[b*8 +: 8];
          end
        end
      end
      rd_tags[w]  <= tag_mem[w][set_idx];
      rd_dirty[w] <= dirty_mem[w][set_idx];
      rd_lines[w] <= data_mem[w][set_idx];
    end
  end

  // Valid bits are the only storage cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_mem[w] <= '0;
      end
      rd_valid <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way_we[w]) begin
          valid_mem[w][set_idx] <= wr_valid;
        end
        rd_valid[w] <= valid_mem[w][set_idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_lookup
  import cache_geom_pkg::*;
(
  input  wire addr_t     req_addr,
  input  wire word_t     req_wdata,
  input  wire wmask_t    req_wmask,
  input  wire tag_t      rd_tags [NUM_WAYS],
  input  wire way_vec_t  rd_dirty,
  input  wire way_vec_t  rd_valid,
  input  wire line_t     rd_lines [NUM_WAYS],
  input  wire way_vec_t  victim,
  output way_vec_t       hit_vec,
  output logic           hit,
  output word_t          rdata,
  output line_t          merge_line,
  output line_mask_t     merge_mask,
  output logic           victim_dirty,
  output addr_t          wb_addr,
  output line_t          wb_line
);

  tag_t                     req_tag;
  set_idx_t                 req_set;
  logic [OFFSET_BITS-3:0]   word_sel;
  tag_t                     wb_tag;

  // Address partition of the registered request
  assign req_tag  = req_addr[ADDR_BITS-1 -: TAG_BITS];
  assign req_set  = req_addr[OFFSET_BITS +: SET_BITS];
  assign word_sel = req_addr[OFFSET_BITS-1:2];

  always_comb begin
    for (int i = 0; i < NUM_WAYS; i++) begin
      hit_vec[i] = rd_valid[i] && (rd_tags[i] == req_tag);
    end
  end

  assign hit = |hit_vec;

  // Hit vector is one-hot, so OR-ing the selected words is enough
  always_comb begin
    rdata = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (hit_vec[i]) begin
        rdata = rdata | rd_lines[i][word_sel*WORD_BITS +: WORD_BITS];
      end
    end
  end

  // Store word and byte mask moved into line position
  assign merge_line = line_t'(req_wdata) << (word_sel * WORD_BITS);
  assign merge_mask = line_mask_t'(req_wmask) << (word_sel * (WORD_BITS / 8));

  // Victim contents for writeback
  always_comb begin
    victim_dirty = 1'b0;
    wb_tag       = '0;
    wb_line      = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (victim[i]) begin
        victim_dirty = rd_valid[i] & rd_dirty[i];
        wb_tag       = rd_tags[i];
        wb_line      = rd_lines[i];
      end
    end
  end

  assign wb_addr = {wb_tag, req_set, {OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

//--- hdl/dcache_control.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_control
  import cache_ctrl_pkg::*;
(
  input  wire   clk,
  input  wire   rst,
  input  wire   req,
  input  wire   req_write,
  input  wire   hit,
  input  wire   victim_dirty,
  input  wire   dfp_resp,
  output logic  idle,
  output logic  ufp_resp,
  output logic  dfp_read,
  output logic  dfp_write,
  output logic  write_cpu,
  output logic  write_mem
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    idle       = 1'b0;
    ufp_resp   = 1'b0;
    dfp_read   = 1'b0;
    dfp_write  = 1'b0;
    write_cpu  = 1'b0;
    write_mem  = 1'b0;

    unique case (state)
      IDLE: begin
        idle = 1'b1;
        if (req) begin
          state_next = COMPARE;
        end
      end
      COMPARE: begin
        if (hit) begin
          ufp_resp   = 1'b1;
          write_cpu  = req_write;
          state_next = IDLE;
        end else if (victim_dirty) begin
          state_next = WRITEBACK;
        end else begin
          state_next = ALLOCATE;
        end
      end
      WRITEBACK: begin
        dfp_write = 1'b1;
        if (dfp_resp) begin
          state_next = ALLOCATE;
        end
      end
      ALLOCATE: begin
        dfp_read = 1'b1;
        if (dfp_resp) begin
          write_mem  = 1'b1;
          state_next = REFILL;
        end
      end
      // One cycle for the arrays to return the new line
      REFILL: begin
        state_next = COMPARE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/dcache_plru.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_plru
  import cache_geom_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire set_idx_t  set_idx,
  input  wire way_vec_t  rd_valid,
  input  wire            touch,
  input  wire way_vec_t  touch_way,
  output way_vec_t       victim
);

  plru_t plru_mem [NUM_SETS];
  plru_t cur_bits;
  plru_t next_bits;

  assign cur_bits = plru_mem[set_idx];

  // Lowest invalid way first, then follow the tree
  always_comb begin
    if (!cur_bits[0]) begin
      victim = cur_bits[1] ? 4'b0010 : 4'b0001;
    end else begin
      victim = cur_bits[2] ? 4'b1000 : 4'b0100;
    end
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!rd_valid[i]) begin
        victim = way_vec_t'(1) << i;
      end
    end
  end

  // Point the path bits away from the accessed way
  always_comb begin
    next_bits = cur_bits;
    case (touch_way)
      4'b0001: begin
        next_bits[0] = 1'b1;
        next_bits[1] = 1'b1;
      end
      4'b0010: begin
        next_bits[0] = 1'b1;
        next_bits[1] = 1'b0;
      end
      4'b0100: begin
        next_bits[0] = 1'b0;
        next_bits[2] = 1'b1;
      end
      4'b1000: begin
        next_bits[0] = 1'b0;
        next_bits[2] = 1'b0;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        plru_mem[s] <= '0;
      end
    end else if (touch) begin
      plru_mem[set_idx] <= next_bits;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  wire          clk,
  input  wire          rst,

  // Processor port
  input  wire addr_t   ufp_addr,
  input  wire wmask_t  ufp_rmask,
  input  wire wmask_t  ufp_wmask,
  input  wire word_t   ufp_wdata,
  output word_t        ufp_rdata,
  output logic         ufp_resp,

  // Line port toward memory
  output addr_t        dfp_addr,
  output logic         dfp_read,
  output logic         dfp_write,
  output line_t        dfp_wdata,
  input  wire line_t   dfp_rdata,
  input  wire          dfp_resp
);

  addr_t       addr_reg;
  wmask_t      wmask_reg;
  word_t       wdata_reg;

  logic        idle;
  logic        req;
  logic        hit;
  logic        victim_dirty;
  logic        write_cpu;
  logic        write_mem;

  set_idx_t    set_idx;
  way_vec_t    way_we;
  tag_t        wr_tag;
  line_t       wr_line;
  line_mask_t  wr_line_mask;

  tag_t        rd_tags  [NUM_WAYS];
  line_t       rd_lines [NUM_WAYS];
  way_vec_t    rd_dirty;
  way_vec_t    rd_valid;
  way_vec_t    hit_vec;
  way_vec_t    victim;
  line_t       merge_line;
  line_mask_t  merge_mask;
  addr_t       wb_addr;

  // Request is captured on every idle cycle
  always_ff @(posedge clk) begin
    if (idle) begin
      addr_reg  <= ufp_addr;
      wmask_reg <= ufp_wmask;
      wdata_reg <= ufp_wdata;
    end
  end

  assign req     = (|ufp_rmask) | (|ufp_wmask);
  assign set_idx = idle ? ufp_addr[OFFSET_BITS +: SET_BITS]
                        : addr_reg[OFFSET_BITS +: SET_BITS];

  // Store hit goes to the hit way, refill to the victim way as a clean line
  assign way_we       = write_cpu ? hit_vec : (write_mem ? victim : '0);
  assign wr_tag       = addr_reg[ADDR_BITS-1 -: TAG_BITS];
  assign wr_line      = write_mem ? dfp_rdata : merge_line;
  assign wr_line_mask = write_mem ? '1 : merge_mask;

  assign dfp_addr = dfp_write ? wb_addr
                              : {addr_reg[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  dcache_arrays arrays0 (
    .clk          (clk),
    .rst          (rst),
    .set_idx      (set_idx),
    .way_we       (way_we),
    .wr_tag       (wr_tag),
    .wr_dirty     (write_cpu),
    .wr_valid     (1'b1),
    .wr_line      (wr_line),
    .wr_line_mask (wr_line_mask),
    .rd_tags      (rd_tags),
    .rd_dirty     (rd_dirty),
    .rd_valid     (rd_valid),
    .rd_lines     (rd_lines)
  );

  dcache_lookup lookup0 (
    .req_addr     (addr_reg),
    .req_wdata    (wdata_reg),
    .req_wmask    (wmask_reg),
    .rd_tags      (rd_tags),
    .rd_dirty     (rd_dirty),
    .rd_valid     (rd_valid),
    .rd_lines     (rd_lines),
    .victim       (victim),
    .hit_vec      (hit_vec),
    .hit          (hit),
    .rdata        (ufp_rdata),
    .merge_line   (merge_line),
    .merge_mask   (merge_mask),
    .victim_dirty (victim_dirty),
    .wb_addr      (wb_addr),
    .wb_line      (dfp_wdata)
  );

  dcache_plru plru0 (
    .clk       (clk),
    .rst       (rst),
    .set_idx   (set_idx),
    .rd_valid  (rd_valid),
    .touch     (ufp_resp),
    .touch_way (hit_vec),
    .victim    (victim)
  );

  dcache_control control0 (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .req_write    (|wmask_reg),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .dfp_resp     (dfp_resp),
    .idle         (idle),
    .ufp_resp     (ufp_resp),
    .dfp_read     (dfp_read),
    .dfp_write    (dfp_write),
    .write_cpu    (write_cpu),
    .write_mem    (write_mem)
  );

endmodule

`default_nettype wire

//--- testbench/dcache_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_model
  import cache_geom_pkg::*;
#(
  parameter int MAX_LAT = 8
)
(
  input  wire         clk,
  input  wire         rst,
  input  wire addr_t  addr,
  input  wire         read,
  input  wire         write,
  input  wire line_t  wdata,
  output line_t       rdata,
  output logic        resp
);

  line_t  lines [addr_t];
  integer seed = 32'h18df8980;
  int     count = 0;
  logic   busy = 1'b0;
  logic   resp_reg = 1'b0;
  line_t  rdata_reg = '0;

  assign resp  = resp_reg;
  assign rdata = rdata_reg;

  // Initial memory image with every byte depending on its full address
  function automatic logic [7:0] fill_byte(input addr_t a);
    logic [7:0] sum;
    sum = a[7:0] + a[15:8] * 8'd3 + a[23:16] * 8'd5 + a[31:24] * 8'd7;
    return sum ^ 8'h5a;
  endfunction

  function automatic line_t stored_line(input addr_t base);
    line_t line;
    if (lines.exists(base)) begin
      return lines[base];
    end
    for (int b = 0; b < LINE_BYTES; b++) begin
      line[b*8 +: 8] = fill_byte(base + b);
    end
    return line;
  endfunction

  // Response comes 3 to MAX_LAT cycles after the request is raised
  always @(posedge clk) begin
    if (rst) begin
      resp_reg <= 1'b0;
      busy     <= 1'b0;
      count    <= 0;
    end else if (resp_reg) begin
      resp_reg <= 1'b0;
      busy     <= 1'b0;
    end else if (busy) begin
      if (count == 0) begin
        resp_reg <= 1'b1;
        if (write) begin
          lines[addr] = wdata;
        end else begin
          rdata_reg <= stored_line(addr);
        end
      end else begin
        count <= count - 1;
      end
    end else if (read || write) begin
      busy  <= 1'b1;
      count <= $unsigned($random(seed)) % (MAX_LAT - 2);
    end
  end

endmodule

`default_nettype wire

//--- testbench/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
  import cache_geom_pkg::*;
();

  localparam int MEM_MAX_LAT     = 8;
  localparam int RANDOM_REQUESTS = 200;
  localparam int NUM_REQUESTS    = 2 + 2 + 11 + 10 + 11 + RANDOM_REQUESTS;
  // Two line transfers plus compare, refill, compare and idle
  localparam int MISS_CYCLES     = 2 * MEM_MAX_LAT + 4;
  localparam int TIMEOUT_CYCLES  = NUM_REQUESTS * MISS_CYCLES * 2;

  logic   clk;
  logic   rst;
  addr_t  ufp_addr;
  wmask_t ufp_rmask;
  wmask_t ufp_wmask;
  word_t  ufp_wdata;
  word_t  ufp_rdata;
  logic   ufp_resp;
  addr_t  dfp_addr;
  logic   dfp_read;
  logic   dfp_write;
  line_t  dfp_wdata;
  line_t  dfp_rdata;
  logic   dfp_resp;

  // Shadow memory and mirror of tags, valid, dirty and tree bits
  logic [7:0] shadow_mem [addr_t];
  tag_t       m_tag   [NUM_SETS][NUM_WAYS];
  bit         m_valid [NUM_SETS][NUM_WAYS];
  bit         m_dirty [NUM_SETS][NUM_WAYS];
  plru_t      m_plru  [NUM_SETS];

  int     errors = 0;
  int     checks = 0;
  int     err_mark = 0;
  int     passed = 0;
  int     failed = 0;
  int     cycle_count = 0;
  int     rd_count = 0;
  int     wr_count = 0;
  int     mem_busy_cycles = 0;
  int     mark_reads;
  int     mark_writes;
  int     mark_busy;
  addr_t  last_rd_addr;
  addr_t  last_wr_addr;
  line_t  last_wr_line;
  integer seed = 32'h18df8980;
  logic [31:0] rnd;
  wmask_t rnd_mask;
  wmask_t store_masks [6] = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b0101, 4'b1010};

  dcache dut0 (
    .clk       (clk),
    .rst       (rst),
    .ufp_addr  (ufp_addr),
    .ufp_rmask (ufp_rmask),
    .ufp_wmask (ufp_wmask),
    .ufp_wdata (ufp_wdata),
    .ufp_rdata (ufp_rdata),
    .ufp_resp  (ufp_resp),
    .dfp_addr  (dfp_addr),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .dfp_wdata (dfp_wdata),
    .dfp_rdata (dfp_rdata),
    .dfp_resp  (dfp_resp)
  );

  dcache_mem_model #(.MAX_LAT(MEM_MAX_LAT)) mem0 (
    .clk   (clk),
    .rst   (rst),
    .addr  (dfp_addr),
    .read  (dfp_read),
    .write (dfp_write),
    .wdata (dfp_wdata),
    .rdata (dfp_rdata),
    .resp  (dfp_resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory port handshakes sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (dfp_read || dfp_write) begin
        mem_busy_cycles++;
      end
      if (dfp_resp && dfp_read) begin
        rd_count++;
        last_rd_addr = dfp_addr;
      end
      if (dfp_resp && dfp_write) begin
        wr_count++;
        last_wr_addr = dfp_addr;
        last_wr_line = dfp_wdata;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(ufp_resp && (dfp_read || dfp_write)))
    else begin
      $display("ERROR t=%0t response given while the memory port was busy", $time);
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp)
    else begin
      $display("ERROR t=%0t ufp_resp stayed high for more than one cycle", $time);
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst) !(dfp_read && dfp_write))
    else begin
      $display("ERROR t=%0t dfp_read and dfp_write raised together", $time);
      errors++;
    end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the cache stopped answering", cycle_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [LINE_BITS-1:0] expected,
                             input logic [LINE_BITS-1:0] actual);
    checks++;
    assert (actual === expected)
      else begin
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        errors++;
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
      else begin
        $display("ERROR t=%0t %s", $time, what);
        errors++;
      end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      passed++;
      $display("Test %s: passed", name);
    end else begin
      failed++;
      $display("Test %s: failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  function automatic logic [7:0] fill_byte(input addr_t a);
    logic [7:0] sum;
    sum = a[7:0] + a[15:8] * 8'd3 + a[23:16] * 8'd5 + a[31:24] * 8'd7;
    return sum ^ 8'h5a;
  endfunction

  function automatic logic [7:0] shadow_byte(input addr_t a);
    if (shadow_mem.exists(a)) begin
      return shadow_mem[a];
    end
    return fill_byte(a);
  endfunction

  function automatic word_t shadow_word(input addr_t a);
    word_t w;
    for (int b = 0; b < 4; b++) begin
      w[b*8 +: 8] = shadow_byte({a[ADDR_BITS-1:2], 2'b00} + b);
    end
    return w;
  endfunction

  function automatic line_t shadow_line(input addr_t base);
    line_t line;
    for (int b = 0; b < LINE_BYTES; b++) begin
      line[b*8 +: 8] = shadow_byte(base + b);
    end
    return line;
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input set_idx_t idx,
                                      input logic [2:0] word);
    return {tag, idx, word, 2'b00};
  endfunction

  // Lowest invalid way, else follow root then pair bit
  function automatic int pick_victim(input set_idx_t idx);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_valid[idx][w]) begin
        return w;
      end
    end
    if (!m_plru[idx][0]) begin
      return m_plru[idx][1] ? 1 : 0;
    end
    return m_plru[idx][2] ? 3 : 2;
  endfunction

  function automatic void touch_way(input set_idx_t idx, input int way);
    if (way < 2) begin
      m_plru[idx][0] = 1'b1;
      m_plru[idx][1] = (way == 0);
    end else begin
      m_plru[idx][0] = 1'b0;
      m_plru[idx][2] = (way == 2);
    end
  endfunction

  // Issue one request on the processor port and check it against the mirror
  task automatic access(input addr_t addr, input logic write, input wmask_t wmask,
                        input word_t wdata);
    set_idx_t idx;
    tag_t     tag;
    int       way;
    logic     exp_hit;
    logic     exp_wb;
    addr_t    wb_addr;
    line_t    wb_line;
    word_t    exp_word;
    int       reads0;
    int       writes0;
    int       busy0;
    int       cycles;
    idx = addr[OFFSET_BITS +: SET_BITS];
    tag = addr[ADDR_BITS-1 -: TAG_BITS];
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        way = w;
      end
    end
    exp_hit = (way >= 0);
    exp_wb  = 1'b0;
    wb_addr = '0;
    wb_line = '0;
    if (!exp_hit) begin
      way    = pick_victim(idx);
      exp_wb = m_valid[idx][way] && m_dirty[idx][way];
      if (exp_wb) begin
        wb_addr = {m_tag[idx][way], idx, {OFFSET_BITS{1'b0}}};
        wb_line = shadow_line(wb_addr);
      end
    end
    exp_word = shadow_word(addr);
    reads0   = rd_count;
    writes0  = wr_count;
    busy0    = mem_busy_cycles;

    @(negedge clk);
    ufp_addr  = addr;
    ufp_rmask = write ? 4'h0 : 4'hf;
    ufp_wmask = write ? wmask : 4'h0;
    ufp_wdata = wdata;
    @(negedge clk);
    cycles = 1;
    while (!ufp_resp) begin
      @(negedge clk);
      cycles++;
    end
    ufp_rmask = 4'h0;
    ufp_wmask = 4'h0;

    if (!write) begin
      check_value("ufp_rdata", exp_word, ufp_rdata);
    end
    if (exp_hit) begin
      check_value("ufp_resp latency", 1, cycles);
      check_value("dfp busy cycles", 0, mem_busy_cycles - busy0);
    end else begin
      check_value("dfp_read transfers", 1, rd_count - reads0);
      check_value("dfp_read address", {addr[ADDR_BITS-1:OFFSET_BITS], 5'b0}, last_rd_addr);
      check_value("dfp_write transfers", exp_wb, wr_count - writes0);
      if (exp_wb) begin
        check_value("dfp_write address", wb_addr, last_wr_addr);
        check_value("dfp_wdata", wb_line, last_wr_line);
      end
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = 1'b0;
      m_tag[idx][way]   = tag;
    end
    if (write) begin
      for (int b = 0; b < 4; b++) begin
        if (wmask[b]) begin
          shadow_mem[{addr[ADDR_BITS-1:2], 2'b00} + b] = wdata[b*8 +: 8];
        end
      end
      m_dirty[idx][way] = 1'b1;
    end
    touch_way(idx, way);
  endtask

  initial begin
    rst       = 1'b1;
    ufp_addr  = '0;
    ufp_rmask = '0;
    ufp_wmask = '0;
    ufp_wdata = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_plru[s] = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    check_value("ufp_resp", 0, ufp_resp);
    check_value("dfp_read", 0, dfp_read);
    check_value("dfp_write", 0, dfp_write);
    access(32'h0000_1014, 1'b0, 4'h0, '0);
    access(32'h0004_2030, 1'b0, 4'h0, '0);
    end_test("reset and cold misses");

    mark_busy = mem_busy_cycles;
    access(32'h0000_1004, 1'b0, 4'h0, '0);
    access(32'h0000_101c, 1'b0, 4'h0, '0);
    check_value("dfp busy cycles", 0, mem_busy_cycles - mark_busy);
    end_test("read hit");

    // Overlapping partial stores to three words of one line
    for (int i = 0; i < 6; i++) begin
      access(32'h0000_1000 + (i % 3) * 4, 1'b1, store_masks[i],
             32'h1122_3344 + i * 32'h0101_0101);
    end
    for (int i = 0; i < 3; i++) begin
      access(32'h0000_1000 + i * 4, 1'b0, 4'h0, '0);
    end
    access(32'h0000_2048, 1'b1, 4'b0011, 32'hdead_beef);
    access(32'h0000_2048, 1'b0, 4'h0, '0);
    end_test("byte-masked stores");

    mark_writes = wr_count;
    for (int i = 0; i < 4; i++) begin
      access(make_addr(tag_t'(23'h100 + i), 4'd5, 3'd0), 1'b0, 4'h0, '0);
      access(make_addr(tag_t'(23'h100 + i), 4'd5, 3'(i)), 1'b1, 4'hf, 32'hc0de_0000 + i);
    end
    access(make_addr(tag_t'(23'h101), 4'd5, 3'd0), 1'b0, 4'h0, '0);
    access(make_addr(tag_t'(23'h104), 4'd5, 3'd0), 1'b0, 4'h0, '0);
    check_true(wr_count > mark_writes, "evicting a dirty line did not write it back");
    end_test("writeback of a dirty victim");

    mark_writes = wr_count;
    for (int i = 0; i < 5; i++) begin
      access(make_addr(tag_t'(23'h180 + i), 4'd9, 3'(i)), 1'b0, 4'h0, '0);
    end
    check_value("dfp_write transfers", 0, wr_count - mark_writes);
    mark_reads = rd_count;
    access(make_addr(tag_t'(23'h180), 4'd9, 3'd0), 1'b0, 4'h0, '0);
    check_value("dfp_read transfers", 1, rd_count - mark_reads);
    // Refetch the lines of set 5 including the one that was written back
    for (int i = 0; i < 5; i++) begin
      access(make_addr(tag_t'(23'h100 + i), 4'd5, 3'(i)), 1'b0, 4'h0, '0);
    end
    end_test("clean eviction and refill");

    for (int i = 0; i < RANDOM_REQUESTS; i++) begin
      rnd      = $random(seed);
      rnd_mask = rnd[11:8];
      if (rnd_mask == 4'h0) begin
        rnd_mask = 4'hf;
      end
      access(make_addr(tag_t'(23'h200 + rnd[15:13] % 6), set_idx_t'(12 + rnd[4:3]), rnd[7:5]),
             rnd[12], rnd_mask, $random(seed));
    end
    end_test("random mix");

    $display("Tests: %0d passed, %0d failed; checks: %0d; errors: %0d",
             passed, failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/dcache_arrays.sv
hdl/dcache_lookup.sv
hdl/dcache_control.sv
hdl/dcache_plru.sv
hdl/dcache.sv
testbench/dcache_mem_model.sv
testbench/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - hdl/cache_geom_pkg.sv
      - hdl/cache_ctrl_pkg.sv
      - hdl/dcache_arrays.sv
      - hdl/dcache_lookup.sv
      - hdl/dcache_control.sv
      - hdl/dcache_plru.sv
      - hdl/dcache.sv
  - target: simulation
    files:
      - testbench/dcache_mem_model.sv
      - testbench/dcache_tb.sv
